// ==== src/exec_pkg.sv ====
package exec_pkg;

    // Datapath and tag widths
    localparam int xlen        = 32;
    localparam int prn_w       = 6;   // Physical register tag
    localparam int robn_w      = 5;   // Reorder buffer tag
    localparam int func_w      = 4;
    localparam int mult_stages = 3;

    // ALU functions
    localparam logic [func_w-1:0] fn_add    = 4'd0;
    localparam logic [func_w-1:0] fn_sub    = 4'd1;
    localparam logic [func_w-1:0] fn_and    = 4'd2;
    localparam logic [func_w-1:0] fn_or     = 4'd3;
    localparam logic [func_w-1:0] fn_xor    = 4'd4;
    localparam logic [func_w-1:0] fn_slt    = 4'd5;
    localparam logic [func_w-1:0] fn_sltu   = 4'd6;
    localparam logic [func_w-1:0] fn_sll    = 4'd7;
    localparam logic [func_w-1:0] fn_srl    = 4'd8;
    localparam logic [func_w-1:0] fn_sra    = 4'd9;
    localparam logic [func_w-1:0] fn_branch = 4'd10;  // Compare only, no writeback value

    // Multiplier functions
    localparam logic [func_w-1:0] fn_mul    = 4'd11;
    localparam logic [func_w-1:0] fn_mulh   = 4'd12;
    localparam logic [func_w-1:0] fn_mulhsu = 4'd13;
    localparam logic [func_w-1:0] fn_mulhu  = 4'd14;

    // Functional unit select
    localparam logic fu_alu  = 1'b0;
    localparam logic fu_mult = 1'b1;

    // Operand A sources
    localparam logic [1:0] opa_rs1  = 2'd0;
    localparam logic [1:0] opa_pc   = 2'd1;
    localparam logic [1:0] opa_zero = 2'd2;

    // Operand B sources
    localparam logic [2:0] opb_rs2   = 3'd0;
    localparam logic [2:0] opb_i_imm = 3'd1;
    localparam logic [2:0] opb_s_imm = 3'd2;
    localparam logic [2:0] opb_b_imm = 3'd3;
    localparam logic [2:0] opb_u_imm = 3'd4;

    // Same 32-bit word seen as I-type or as S/B-type
    typedef union packed {
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;  // imm[11:5] or imm[12|10:5]
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;  // imm[4:0] or imm[4:1|11]
            logic [6:0] opcode;
        } s;
    } inst_t;

endpackage

// ==== src/operand_select.sv ====
`timescale 1ns/1ps

module operand_select import exec_pkg::*; (
    input  logic              clock,
    input  logic              rst,
    input  logic              issue_valid,
    input  logic              issue_fu,
    input  logic [func_w-1:0] issue_func,
    input  logic [xlen-1:0]   issue_op1,
    input  logic [xlen-1:0]   issue_op2,
    input  logic [xlen-1:0]   issue_pc,
    input  inst_t             issue_inst,
    input  logic [1:0]        issue_opa_sel,
    input  logic [2:0]        issue_opb_sel,
    input  logic [prn_w-1:0]  issue_prn,
    input  logic [robn_w-1:0] issue_robn,
    input  logic              alu_ready,
    input  logic              mult_ready,
    output logic              ex_alu_valid,
    output logic              ex_mult_valid,
    output logic [func_w-1:0] ex_func,
    output logic [xlen-1:0]   ex_opa,
    output logic [xlen-1:0]   ex_opb,
    output logic [xlen-1:0]   ex_rs1,
    output logic [xlen-1:0]   ex_rs2,
    output logic [2:0]        ex_cond,
    output logic [xlen-1:0]   ex_branch_off,
    output logic [prn_w-1:0]  ex_prn,
    output logic [robn_w-1:0] ex_robn
);

    logic [xlen-1:0] i_imm, s_imm, b_imm, u_imm;
    logic [xlen-1:0] opa_mux, opb_mux;
    logic            advance;
    logic            accept_alu, accept_mult;

    assign i_imm = {{(xlen-12){issue_inst.i.imm[11]}}, issue_inst.i.imm};
    assign s_imm = {{(xlen-12){issue_inst.s.imm_hi[6]}}, issue_inst.s.imm_hi, issue_inst.s.imm_lo};
    assign b_imm = {{(xlen-12){issue_inst.s.imm_hi[6]}}, issue_inst.s.imm_lo[0],
                    issue_inst.s.imm_hi[5:0], issue_inst.s.imm_lo[4:1], 1'b0};
    // Upper 20 bits of the word, low 12 zero
    assign u_imm = {issue_inst.i.imm, issue_inst.i.rs1, issue_inst.i.funct3, 12'b0};

    always_comb begin
        case (issue_opa_sel)
            opa_rs1:  opa_mux = issue_op1;
            opa_pc:   opa_mux = issue_pc;
            opa_zero: opa_mux = '0;
            default:  opa_mux = '0;
        endcase
    end

    always_comb begin
        case (issue_opb_sel)
            opb_rs2:   opb_mux = issue_op2;
            opb_i_imm: opb_mux = i_imm;
            opb_s_imm: opb_mux = s_imm;
            opb_b_imm: opb_mux = b_imm;
            opb_u_imm: opb_mux = u_imm;
            default:   opb_mux = '0;
        endcase
    end

    // Both units freeze together, so the shared stage holds on either stall
    assign advance     = alu_ready & mult_ready;
    assign accept_alu  = issue_valid & (issue_fu == fu_alu) & alu_ready;
    assign accept_mult = issue_valid & (issue_fu == fu_mult) & mult_ready;

    always_ff @(posedge clock) begin
        if (rst) begin
            ex_alu_valid  <= 1'b0;
            ex_mult_valid <= 1'b0;
        end else if (advance) begin
            ex_alu_valid  <= accept_alu;
            ex_mult_valid <= accept_mult;
        end
    end

    always_ff @(posedge clock) begin
        if (advance && issue_valid) begin
            ex_func       <= issue_func;
            ex_opa        <= opa_mux;
            ex_opb        <= opb_mux;
            ex_rs1        <= issue_op1;
            ex_rs2        <= issue_op2;
            ex_cond       <= issue_inst.s.funct3;  // Branch condition
            ex_branch_off <= b_imm;
            ex_prn        <= issue_prn;
            ex_robn       <= issue_robn;
        end
    end

    // Issuer must respect the avail bit fed back from completion
    a_issue_ready: assert property (@(posedge clock) disable iff (rst)
        issue_valid |-> ((issue_fu == fu_mult) ? mult_ready : alu_ready));

endmodule

// ==== src/alu_branch.sv ====
`timescale 1ns/1ps

module alu_branch import exec_pkg::*; (
    input  logic              clock,
    input  logic              rst,
    input  logic              ex_alu_valid,
    input  logic [func_w-1:0] ex_func,
    input  logic [xlen-1:0]   ex_opa,
    input  logic [xlen-1:0]   ex_opb,
    input  logic [xlen-1:0]   ex_rs1,
    input  logic [xlen-1:0]   ex_rs2,
    input  logic [2:0]        ex_cond,
    input  logic [xlen-1:0]   ex_branch_off,
    input  logic [prn_w-1:0]  ex_prn,
    input  logic [robn_w-1:0] ex_robn,
    input  logic              hold,
    output logic              alu_done,
    output logic [xlen-1:0]   alu_value,
    output logic              alu_taken,
    output logic [xlen-1:0]   alu_target,
    output logic [prn_w-1:0]  alu_prn,
    output logic [robn_w-1:0] alu_robn
);

    logic signed [xlen-1:0] sopa, sopb;
    logic signed [xlen-1:0] srs1, srs2;
    logic [xlen-1:0]        result;
    logic                   take;

    assign sopa = ex_opa;
    assign sopb = ex_opb;
    assign srs1 = ex_rs1;
    assign srs2 = ex_rs2;

    // Condition codes follow funct3 of the branch
    always_comb begin
        case (ex_cond)
            3'b000:  take = ex_rs1 == ex_rs2;  // BEQ
            3'b001:  take = ex_rs1 != ex_rs2;  // BNE
            3'b100:  take = srs1 <  srs2;      // BLT
            3'b101:  take = srs1 >= srs2;      // BGE
            3'b110:  take = ex_rs1 <  ex_rs2;  // BLTU
            3'b111:  take = ex_rs1 >= ex_rs2;  // BGEU
            default: take = 1'b0;
        endcase
    end

    always_comb begin
        case (ex_func)
            fn_add:    result = ex_opa + ex_opb;
            fn_sub:    result = ex_opa - ex_opb;
            fn_and:    result = ex_opa & ex_opb;
            fn_or:     result = ex_opa | ex_opb;
            fn_xor:    result = ex_opa ^ ex_opb;
            fn_slt:    result = {{(xlen-1){1'b0}}, sopa < sopb};
            fn_sltu:   result = {{(xlen-1){1'b0}}, ex_opa < ex_opb};
            fn_sll:    result = ex_opa << ex_opb[4:0];
            fn_srl:    result = ex_opa >> ex_opb[4:0];
            fn_sra:    result = sopa >>> ex_opb[4:0];
            fn_branch: result = {{(xlen-1){1'b0}}, take};  // Flag only
            default:   result = '0;
        endcase
    end

    // Frozen while the arbiter still owns an older ALU result
    always_ff @(posedge clock) begin
        if (rst) begin
            alu_done <= 1'b0;
        end else if (!hold) begin
            alu_done <= ex_alu_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (!hold) begin
            alu_value  <= result;
            alu_taken  <= (ex_func == fn_branch) & take;
            alu_target <= ex_opa + ex_branch_off;  // opa carries the PC
            alu_prn    <= ex_prn;
            alu_robn   <= ex_robn;
        end
    end

endmodule

// ==== src/mult_pipe.sv ====
`timescale 1ns/1ps

module mult_pipe import exec_pkg::*; (
    input  logic              clock,
    input  logic              rst,
    input  logic              ex_mult_valid,
    input  logic [func_w-1:0] ex_func,
    input  logic [xlen-1:0]   ex_opa,
    input  logic [xlen-1:0]   ex_opb,
    input  logic [prn_w-1:0]  ex_prn,
    input  logic [robn_w-1:0] ex_robn,
    input  logic              mult_stall,
    output logic              mult_done,
    output logic [xlen-1:0]   mult_value,
    output logic [prn_w-1:0]  mult_prn,
    output logic [robn_w-1:0] mult_robn
);

    logic [mult_stages-1:0]  vld;
    logic [prn_w-1:0]        prn_q  [mult_stages];
    logic [robn_w-1:0]       robn_q [mult_stages];
    logic                    a_signed, b_signed;
    logic signed [xlen:0]    s1_a, s1_b;  // 33 bit operands
    logic                    s1_hi, s2_hi;
    logic signed [2*xlen+1:0] full_prod;
    logic [2*xlen-1:0]       s2_prod;

    assign a_signed = (ex_func == fn_mulh) | (ex_func == fn_mulhsu);
    assign b_signed = (ex_func == fn_mulh);

    assign full_prod = s1_a * s1_b;

    always_ff @(posedge clock) begin
        if (rst) begin
            vld <= '0;
        end else if (!mult_stall) begin
            vld <= {vld[mult_stages-2:0], ex_mult_valid};
        end
    end

    always_ff @(posedge clock) begin
        if (!mult_stall) begin
            // Stage 1 extends the operands
            s1_a  <= {a_signed & ex_opa[xlen-1], ex_opa};
            s1_b  <= {b_signed & ex_opb[xlen-1], ex_opb};
            s1_hi <= (ex_func != fn_mul);  // Every high-half variant
            // Stage 2 multiplies
            s2_prod <= full_prod[2*xlen-1:0];
            s2_hi   <= s1_hi;
            // Stage 3 picks the word
            mult_value <= s2_hi ? s2_prod[2*xlen-1:xlen] : s2_prod[xlen-1:0];
            prn_q[0]  <= ex_prn;
            robn_q[0] <= ex_robn;
            for (int i = 1; i < mult_stages; i++) begin
                prn_q[i]  <= prn_q[i-1];
                robn_q[i] <= robn_q[i-1];
            end
        end
    end

    assign mult_done = vld[mult_stages-1];
    assign mult_prn  = prn_q[mult_stages-1];
    assign mult_robn = robn_q[mult_stages-1];

endmodule

// ==== src/complete_arbiter.sv ====
`timescale 1ns/1ps

module complete_arbiter import exec_pkg::*; (
    input  logic              clock,
    input  logic              rst,
    input  logic              alu_done,
    input  logic [xlen-1:0]   alu_value,
    input  logic              alu_taken,
    input  logic [xlen-1:0]   alu_target,
    input  logic [prn_w-1:0]  alu_prn,
    input  logic [robn_w-1:0] alu_robn,
    input  logic              mult_done,
    input  logic [xlen-1:0]   mult_value,
    input  logic [prn_w-1:0]  mult_prn,
    input  logic [robn_w-1:0] mult_robn,
    output logic              mult_stall,
    output logic              alu_hold_full,
    output logic              cdb_valid,
    output logic [prn_w-1:0]  cdb_prn,
    output logic [xlen-1:0]   cdb_value,
    output logic              rob_valid,
    output logic [robn_w-1:0] rob_robn,
    output logic              rob_branch_taken,
    output logic [xlen-1:0]   rob_target
);

    logic              hold_valid;
    logic [xlen-1:0]   hold_value;
    logic              hold_taken;
    logic [xlen-1:0]   hold_target;
    logic [prn_w-1:0]  hold_prn;
    logic [robn_w-1:0] hold_robn;
    logic              load_hold;
    logic              out_valid;

    // ALU loses only on a tie with the multiplier
    assign load_hold     = !hold_valid && alu_done && mult_done;
    assign alu_hold_full = hold_valid;
    assign mult_stall    = hold_valid;  // Held ALU result goes out first

    always_ff @(posedge clock) begin
        if (rst) begin
            hold_valid <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            hold_valid <= load_hold;
            out_valid  <= hold_valid | alu_done | mult_done;
        end
    end

    always_ff @(posedge clock) begin
        if (load_hold) begin
            hold_value  <= alu_value;
            hold_taken  <= alu_taken;
            hold_target <= alu_target;
            hold_prn    <= alu_prn;
            hold_robn   <= alu_robn;
        end
        if (hold_valid) begin
            cdb_prn <= hold_prn;
            cdb_value <= hold_value;
            rob_robn <= hold_robn;
            rob_branch_taken <= hold_taken;
            rob_target <= hold_target;
        end else if (mult_done) begin
            cdb_prn <= mult_prn;
            cdb_value <= mult_value;
            rob_robn <= mult_robn;
            rob_branch_taken <= 1'b0;
            rob_target <= '0;
        end else begin
            cdb_prn <= alu_prn;
            cdb_value <= alu_value;
            rob_robn <= alu_robn;
            rob_branch_taken <= alu_taken;
            rob_target <= alu_target;
        end
    end

    assign cdb_valid = out_valid;
    assign rob_valid = out_valid;

    // ALU stage must freeze while the entry is full, or a newer result would be lost
    a_alu_frozen: assert property (@(posedge clock) disable iff (rst)
        hold_valid |=> $stable(alu_done) && $stable(alu_robn));

    a_cdb_known: assert property (@(posedge clock) disable iff (rst)
        !$isunknown(cdb_valid));

endmodule

// ==== src/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit import exec_pkg::*; (
    input  logic              clock,
    input  logic              rst,
    input  logic              issue_valid,
    input  logic              issue_fu,
    input  logic [func_w-1:0] issue_func,
    input  logic [xlen-1:0]   issue_op1,
    input  logic [xlen-1:0]   issue_op2,
    input  logic [xlen-1:0]   issue_pc,
    input  inst_t             issue_inst,
    input  logic [1:0]        issue_opa_sel,
    input  logic [2:0]        issue_opb_sel,
    input  logic [prn_w-1:0]  issue_prn,
    input  logic [robn_w-1:0] issue_robn,
    output logic              alu_avail,
    output logic              mult_avail,
    output logic              cdb_valid,
    output logic [prn_w-1:0]  cdb_prn,
    output logic [xlen-1:0]   cdb_value,
    output logic              rob_valid,
    output logic [robn_w-1:0] rob_robn,
    output logic              rob_branch_taken,
    output logic [xlen-1:0]   rob_target
);

    logic              ex_alu_valid, ex_mult_valid;
    logic [func_w-1:0] ex_func;
    logic [xlen-1:0]   ex_opa, ex_opb, ex_rs1, ex_rs2, ex_branch_off;
    logic [2:0]        ex_cond;
    logic [prn_w-1:0]  ex_prn, alu_prn, mult_prn;
    logic [robn_w-1:0] ex_robn, alu_robn, mult_robn;
    logic              alu_done, alu_taken, mult_done;
    logic [xlen-1:0]   alu_value, alu_target, mult_value;
    logic              mult_stall, alu_hold_full;

    assign alu_avail  = ~alu_hold_full;
    assign mult_avail = ~mult_stall;

    operand_select u_operand_select (
        .clock, .rst, .issue_valid, .issue_fu, .issue_func, .issue_op1, .issue_op2,
        .issue_pc, .issue_inst, .issue_opa_sel, .issue_opb_sel, .issue_prn, .issue_robn,
        .alu_ready(alu_avail), .mult_ready(mult_avail),
        .ex_alu_valid, .ex_mult_valid, .ex_func, .ex_opa, .ex_opb, .ex_rs1, .ex_rs2,
        .ex_cond, .ex_branch_off, .ex_prn, .ex_robn
    );

    alu_branch u_alu_branch (
        .clock, .rst, .ex_alu_valid, .ex_func, .ex_opa, .ex_opb, .ex_rs1, .ex_rs2,
        .ex_cond, .ex_branch_off, .ex_prn, .ex_robn, .hold(alu_hold_full),
        .alu_done, .alu_value, .alu_taken, .alu_target, .alu_prn, .alu_robn
    );

    mult_pipe u_mult_pipe (
        .clock, .rst, .ex_mult_valid, .ex_func, .ex_opa, .ex_opb, .ex_prn, .ex_robn,
        .mult_stall, .mult_done, .mult_value, .mult_prn, .mult_robn
    );

    complete_arbiter u_complete_arbiter (
        .clock, .rst, .alu_done, .alu_value, .alu_taken, .alu_target, .alu_prn, .alu_robn,
        .mult_done, .mult_value, .mult_prn, .mult_robn, .mult_stall, .alu_hold_full,
        .cdb_valid, .cdb_prn, .cdb_value, .rob_valid, .rob_robn, .rob_branch_taken,
        .rob_target
    );

endmodule

// ==== sim/tb_exec_unit.sv ====
`timescale 1ns/1ps

module tb_exec_unit import exec_pkg::*; ();

    logic              clock;
    logic              rst;
    logic              issue_valid;
    logic              issue_fu;
    logic [func_w-1:0] issue_func;
    logic [xlen-1:0]   issue_op1, issue_op2, issue_pc;
    inst_t             issue_inst;
    logic [1:0]        issue_opa_sel;
    logic [2:0]        issue_opb_sel;
    logic [prn_w-1:0]  issue_prn;
    logic [robn_w-1:0] issue_robn;
    logic              alu_avail, mult_avail;
    logic              cdb_valid, rob_valid, rob_branch_taken;
    logic [prn_w-1:0]  cdb_prn;
    logic [xlen-1:0]   cdb_value, rob_target;
    logic [robn_w-1:0] rob_robn;

    // Fields of the current stimulus line
    logic              f_fu, f_taken;
    logic [func_w-1:0] f_func;
    logic [xlen-1:0]   f_op1, f_op2, f_pc, f_inst, f_value, f_target;
    logic [1:0]        f_asel;
    logic [2:0]        f_bsel;
    logic [prn_w-1:0]  f_prn;
    logic [robn_w-1:0] f_robn;

    // Scoreboard indexed by robn
    logic [xlen-1:0]   exp_val [32];
    logic [xlen-1:0]   exp_tgt [32];
    logic [prn_w-1:0]  exp_prn [32];
    logic [func_w-1:0] exp_func [32];
    logic              exp_taken [32];
    bit                issued [32];
    bit                seen [32];

    int pass_count = 0;
    int fail_count = 0;
    bit timed_out = 1'b0;

    exec_unit uut (
        .clock, .rst, .issue_valid, .issue_fu, .issue_func, .issue_op1, .issue_op2,
        .issue_pc, .issue_inst, .issue_opa_sel, .issue_opb_sel, .issue_prn, .issue_robn,
        .alu_avail, .mult_avail, .cdb_valid, .cdb_prn, .cdb_value, .rob_valid,
        .rob_robn, .rob_branch_taken, .rob_target
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic bit all_seen();
        for (int r = 0; r < 32; r++) begin
            if (issued[r] && !seen[r]) return 1'b0;
        end
        return 1'b1;
    endfunction

    // Holds off until the chosen unit is free, then issues for one cycle
    task automatic wait_and_issue();
        int waited;
        waited = 0;
        while (((f_fu == fu_mult) ? mult_avail : alu_avail) !== 1'b1 && waited < 50) begin
            @(posedge clock);
            #1;
            waited++;
        end
        if (((f_fu == fu_mult) ? mult_avail : alu_avail) !== 1'b1) begin
            $display("Timed out at %0t waiting for unit %0d to accept robn %0d",
                     $time, f_fu, f_robn);
            timed_out = 1'b1;
            fail_count++;
        end else begin
            exp_val[f_robn]   = f_value;
            exp_tgt[f_robn]   = f_target;
            exp_prn[f_robn]   = f_prn;
            exp_func[f_robn]  = f_func;
            exp_taken[f_robn] = f_taken;
            issued[f_robn]    = 1'b1;
            issue_fu      = f_fu;
            issue_func    = f_func;
            issue_op1     = f_op1;
            issue_op2     = f_op2;
            issue_pc      = f_pc;
            issue_inst    = f_inst;
            issue_opa_sel = f_asel;
            issue_opb_sel = f_bsel;
            issue_prn     = f_prn;
            issue_robn    = f_robn;
            issue_valid   = 1'b1;
            @(posedge clock);
            #1;
            issue_valid = 1'b0;
        end
    endtask

    // ROB and CDB valids move together in every cycle
    always @(negedge clock) begin
        if (!rst) begin
            assert (rob_valid === cdb_valid) else begin
                $display("MISMATCH at %0t: rob_valid %b differs from cdb_valid %b",
                         $time, rob_valid, cdb_valid);
                fail_count++;
            end
        end
    end

    // Mid-cycle sampling of the registered CDB and ROB outputs
    always @(negedge clock) begin
        logic [robn_w-1:0] r;
        bit                item_ok;
        if (!rst && cdb_valid === 1'b1) begin
            r = rob_robn;
            item_ok = 1'b1;
            assert (issued[r] && !seen[r]) else begin
                $display("Unexpected or repeated completion of robn %0d at %0t", r, $time);
                item_ok = 1'b0;
            end
            assert (cdb_prn == exp_prn[r]) else begin
                $display("MISMATCH at %0t: robn %0d prn %h, expected %h",
                         $time, r, cdb_prn, exp_prn[r]);
                item_ok = 1'b0;
            end
            assert (cdb_value == exp_val[r]) else begin
                $display("MISMATCH at %0t: robn %0d value %h, expected %h",
                         $time, r, cdb_value, exp_val[r]);
                item_ok = 1'b0;
            end
            assert (rob_branch_taken == exp_taken[r]) else begin
                $display("MISMATCH at %0t: robn %0d taken %b, expected %b",
                         $time, r, rob_branch_taken, exp_taken[r]);
                item_ok = 1'b0;
            end
            if (exp_func[r] == fn_branch) begin  // Target only means something for branches
                assert (rob_target == exp_tgt[r]) else begin
                    $display("MISMATCH at %0t: robn %0d target %h, expected %h",
                             $time, r, rob_target, exp_tgt[r]);
                    item_ok = 1'b0;
                end
            end
            seen[r] = 1'b1;
            if (item_ok) pass_count++;
            else fail_count++;
            $display("test robn %0d: %s", r, item_ok ? "pass" : "FAIL");
        end
    end

    initial begin
        int    fd;
        int    n;
        int    waited;
        string line;
        rst = 1'b1;
        issue_valid = 1'b0;
        issue_fu = fu_alu;
        issue_func = fn_add;
        issue_op1 = '0;
        issue_op2 = '0;
        issue_pc = '0;
        issue_inst = '0;
        issue_opa_sel = opa_rs1;
        issue_opb_sel = opb_rs2;
        issue_prn = '0;
        issue_robn = '0;
        repeat (4) @(posedge clock);
        #1;
        rst = 1'b0;

        assert (cdb_valid === 1'b0 && alu_avail === 1'b1 && mult_avail === 1'b1) else begin
            $display("MISMATCH at %0t: after reset cdb_valid %b alu_avail %b mult_avail %b",
                     $time, cdb_valid, alu_avail, mult_avail);
            fail_count++;
        end
        if (fail_count == 0) pass_count++;
        $display("test reset: %s", (fail_count == 0) ? "pass" : "FAIL");

        fd = $fopen("sim/exec_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file sim/exec_input.txt");
            fail_count++;
        end else begin
            while (!timed_out && $fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.substr(0, 0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                                f_fu, f_func, f_op1, f_op2, f_pc, f_inst, f_asel, f_bsel,
                                f_prn, f_robn, f_value, f_taken, f_target);
                    if (n == 13) begin
                        wait_and_issue();
                    end else begin
                        $display("Malformed stimulus line: %s", line);
                        fail_count++;
                    end
                end
            end
            $fclose(fd);
        end

        // Drain every outstanding tag
        waited = 0;
        while (!timed_out && !all_seen() && waited < 200) begin
            @(posedge clock);
            waited++;
        end
        for (int r = 0; r < 32; r++) begin
            if (issued[r] && !seen[r]) begin
                $display("Tag %0d was issued but never completed on the CDB", r);
                fail_count++;
            end
        end

        $display("Done: %0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0 && pass_count > 1) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
src/exec_pkg.sv
src/operand_select.sv
src/alu_branch.sv
src/mult_pipe.sv
src/complete_arbiter.sv
src/exec_unit.sv
sim/tb_exec_unit.sv

// ==== Bender.yml ====
package:
  name: exec_unit

sources:
  - src/exec_pkg.sv
  - src/operand_select.sv
  - src/alu_branch.sv
  - src/mult_pipe.sv
  - src/complete_arbiter.sv
  - src/exec_unit.sv
  - target: test
    files:
      - sim/tb_exec_unit.sv

// ==== sim/exec_input.txt ====
# fu func op1 op2 pc inst opa_sel opb_sel prn robn | expected: value taken target
# All fields hex, target only checked on branches (func a)
0 0 00000005 00000007 00000000 00000000 0 0 20 00 0000000c 0 00000000
0 1 00000003 00000005 00000000 00000000 0 0 21 01 fffffffe 0 00000000
0 2 f0f0f0f0 0ff00ff0 00000000 00000000 0 0 22 02 00f000f0 0 00000000
0 3 f0f0f0f0 0ff00ff0 00000000 00000000 0 0 23 03 fff0fff0 0 00000000
0 4 f0f0f0f0 0ff00ff0 00000000 00000000 0 0 24 04 ff00ff00 0 00000000
0 5 ffffffff 00000001 00000000 00000000 0 0 25 05 00000001 0 00000000
0 6 ffffffff 00000001 00000000 00000000 0 0 26 06 00000000 0 00000000
0 7 00000003 00000024 00000000 00000000 0 0 27 07 00000030 0 00000000
0 8 80000000 00000004 00000000 00000000 0 0 28 08 08000000 0 00000000
0 9 80000000 00000004 00000000 00000000 0 0 29 09 f8000000 0 00000000
0 0 00000000 00000000 00001000 12345017 1 4 2a 0a 12346000 0 00000000
0 0 00000000 00000000 00001004 fffff0b7 2 4 2b 0b fffff000 0 00000000
0 0 00000010 00000000 00000000 fff00093 0 1 2c 0c 0000000f 0 00000000
0 0 00000100 00000000 00000000 fe20ac23 0 2 2d 0d 000000f8 0 00000000
0 a 00000005 00000005 00002000 00208863 1 3 2e 0e 00000001 1 00002010
0 a 00000005 00000005 00002004 00209863 1 3 2f 0f 00000000 0 00002014
0 a ffffffff 00000001 00002008 0020c863 1 3 30 10 00000001 1 00002018
0 a ffffffff 00000001 0000200c 0020d863 1 3 31 11 00000000 0 0000201c
0 a ffffffff 00000001 00002010 0020e863 1 3 32 12 00000000 0 00002020
0 a ffffffff 00000001 00002014 fe20f8e3 1 3 33 13 00000001 1 00002004
1 b 00000007 00000006 00000000 00000000 0 0 34 14 0000002a 0 00000000
1 c 80000000 80000000 00000000 00000000 0 0 35 15 40000000 0 00000000
1 d ffffffff ffffffff 00000000 00000000 0 0 36 16 ffffffff 0 00000000
0 0 00000100 00000023 00000000 00000000 0 0 37 17 00000123 0 00000000
0 4 0000ffff 00ff00ff 00000000 00000000 0 0 38 18 00ffff00 0 00000000
1 e ffffffff ffffffff 00000000 00000000 0 0 39 19 fffffffe 0 00000000
1 b 80000000 ffffffff 00000000 00000000 0 0 3a 1a 80000000 0 00000000
0 1 00000000 00000001 00000000 00000000 0 0 3b 1b ffffffff 0 00000000
1 c 7fffffff 80000000 00000000 00000000 0 0 3c 1c c0000000 0 00000000
0 7 00000001 0000001f 00000000 00000000 0 0 3d 1d 80000000 0 00000000
0 9 ffffff00 00000004 00000000 00000000 0 0 3e 1e fffffff0 0 00000000
